// File: rtl/arith_pkg.sv
// Shared widths, opcodes, saturation limits and the word/lane view of the arithmetic unit.
package arith_pkg;

	// ==============================
	// Data widths
	// ==============================
	localparam int WORD_W = 16; // Width of a machine word.
	localparam int LANE_W = 4;  // Width of one PADDSB lane.
	localparam int LANES  = 4;  // Number of lanes in a word.

	// ==============================
	// Opcodes
	// ==============================
	localparam logic [1:0] OP_ADD    = 2'd0; // Saturating 16-bit add.
	localparam logic [1:0] OP_SUB    = 2'd1; // Saturating 16-bit subtract.
	localparam logic [1:0] OP_PADDSB = 2'd2; // Four signed lanes, each saturating.
	localparam logic [1:0] OP_RED    = 2'd3; // Sum of all eight nibbles.

	// ==============================
	// Saturation limits
	// ==============================
	localparam logic [WORD_W-1:0] SAT_POS = 16'h7FFF; // Largest positive word.
	localparam logic [WORD_W-1:0] SAT_NEG = 16'h8000; // Most negative word.
	localparam logic [LANE_W-1:0] LANE_SAT_POS = 4'h7; // Largest positive lane.
	localparam logic [LANE_W-1:0] LANE_SAT_NEG = 4'h8; // Most negative lane.

	// A result word read either whole or as four lanes, lane 0 in the low bits.
	typedef union packed {
		logic [WORD_W-1:0] word;               // Whole 16-bit value.
		logic [LANES-1:0][LANE_W-1:0] lanes;   // Same bits split into nibbles.
	} arith_word_u;

endpackage

// File: rtl/cla_4bit.sv
// Four-bit carry-lookahead lane with group terms and signed lane saturation for PADDSB.
`timescale 1ns/1ps

module cla_4bit (
	input  logic [arith_pkg::LANE_W-1:0] a,  // Lane addend A.
	input  logic [arith_pkg::LANE_W-1:0] b,  // Lane addend B.
	input  logic                         c0, // Carry into the lane.
	input  logic                         sat, // PADDSB in progress.
	input  logic                         red, // RED in progress.
	output logic [arith_pkg::LANE_W-1:0] s,  // Lane sum, clamped under PADDSB.
	output logic                         g,  // Group generate.
	output logic                         p   // Group propagate.
);

	logic [arith_pkg::LANE_W-1:0] bit_g; // Per-bit generate.
	logic [arith_pkg::LANE_W-1:0] bit_p; // Per-bit propagate.
	logic [arith_pkg::LANE_W-1:0] carry; // Carry into each bit position.
	logic [arith_pkg::LANE_W-1:0] s_raw; // Unclamped lane sum.
	logic                         c_in;  // Carry-in after lane isolation.
	logic                         pos_ovfl;
	logic                         neg_ovfl;

	// ==============================
	// Lookahead carries
	// ==============================
	assign c_in  = c0 & ~(sat | red); // Lanes stay isolated for PADDSB and RED.
	assign bit_g = a & b;
	assign bit_p = a ^ b;

	assign carry[0] = c_in;
	assign carry[1] = bit_g[0] | (bit_p[0] & c_in); // Carry into bit 1.
	assign carry[2] = bit_g[1] | (bit_p[1] & bit_g[0]) |
		(bit_p[1] & bit_p[0] & c_in);                   // Carry into bit 2.
	assign carry[3] = bit_g[2] | (bit_p[2] & bit_g[1]) |
		(bit_p[2] & bit_p[1] & bit_g[0]) |
		(bit_p[2] & bit_p[1] & bit_p[0] & c_in);        // Carry into bit 3.

	assign s_raw = bit_p ^ carry; // Sum bits.

	// Group terms feed the second-level block; with no carry-in g is the carry-out.
	assign g = bit_g[3] | (bit_p[3] & bit_g[2]) | (bit_p[3] & bit_p[2] & bit_g[1]) |
		(bit_p[3] & bit_p[2] & bit_p[1] & bit_g[0]);
	assign p = &bit_p; // Lane passes a carry straight through.

	// ==============================
	// Lane saturation
	// ==============================
	assign pos_ovfl = sat & ~a[arith_pkg::LANE_W-1] & ~b[arith_pkg::LANE_W-1] &
		s_raw[arith_pkg::LANE_W-1]; // Two positives gave a negative.
	assign neg_ovfl = sat & a[arith_pkg::LANE_W-1] & b[arith_pkg::LANE_W-1] &
		~s_raw[arith_pkg::LANE_W-1]; // Two negatives gave a non-negative.

	assign s = pos_ovfl ? arith_pkg::LANE_SAT_POS :
		neg_ovfl ? arith_pkg::LANE_SAT_NEG :
		s_raw; // Clamp to +7 or -8 only on a lane overflow.

endmodule

// File: rtl/cla_carry_block.sv
// Second-level carry lookahead that turns lane generate/propagate terms into lane carries.
`timescale 1ns/1ps

module cla_carry_block (
	input  logic [arith_pkg::LANES-1:0] g_in,  // Lane generates, lane 0 in bit 0.
	input  logic [arith_pkg::LANES-1:0] p_in,  // Lane propagates.
	input  logic                        c0,    // Carry into lane 0.
	output logic                        c1,    // Carry into lane 1.
	output logic                        c2,    // Carry into lane 2.
	output logic                        c3,    // Carry into lane 3.
	output logic                        g_out, // 16-bit group generate.
	output logic                        p_out  // 16-bit group propagate.
);

	// Each carry is a lane generate or an earlier term passed through.
	assign c1 = g_in[0] | (p_in[0] & c0);
	assign c2 = g_in[1] | (p_in[1] & g_in[0]) | (p_in[1] & p_in[0] & c0);
	assign c3 = g_in[2] | (p_in[2] & g_in[1]) | (p_in[2] & p_in[1] & g_in[0]) |
		(p_in[2] & p_in[1] & p_in[0] & c0);

	// ==============================
	// Group terms
	// ==============================
	assign g_out = g_in[3] | (p_in[3] & g_in[2]) | (p_in[3] & p_in[2] & g_in[1]) |
		(p_in[3] & p_in[2] & p_in[1] & g_in[0]); // Word generates a carry.
	assign p_out = &p_in; // Word propagates its carry-in.

endmodule

// File: rtl/nibble_reduction.sv
// Reduction tree that adds the four isolated lane sums into the RED result.
`timescale 1ns/1ps

module nibble_reduction (
	input  logic [arith_pkg::LANE_W-1:0] s0,    // Lane 0 sum.
	input  logic [arith_pkg::LANE_W-1:0] s1,    // Lane 1 sum.
	input  logic [arith_pkg::LANE_W-1:0] s2,    // Lane 2 sum.
	input  logic [arith_pkg::LANE_W-1:0] s3,    // Lane 3 sum.
	input  logic                         g0,    // Lane 0 carry-out.
	input  logic                         g1,    // Lane 1 carry-out.
	input  logic                         g2,    // Lane 2 carry-out.
	input  logic                         g3,    // Lane 3 carry-out.
	output logic [arith_pkg::WORD_W-1:0] s_red  // Zero-extended total.
);

	logic [4:0] lane_tot0; // Lane 0 total, at most 30.
	logic [4:0] lane_tot1;
	logic [4:0] lane_tot2;
	logic [4:0] lane_tot3;
	logic [5:0] sum_lo;    // Lanes 0 and 1, at most 60.
	logic [5:0] sum_hi;    // Lanes 2 and 3.
	logic [6:0] total;     // All lanes, at most 120.

	// The carry-out is the fifth bit of each unsigned lane total.
	assign lane_tot0 = {g0, s0};
	assign lane_tot1 = {g1, s1};
	assign lane_tot2 = {g2, s2};
	assign lane_tot3 = {g3, s3};

	// ==============================
	// Two-level adder tree
	// ==============================
	assign sum_lo = {1'b0, lane_tot0} + {1'b0, lane_tot1}; // First level, low pair.
	assign sum_hi = {1'b0, lane_tot2} + {1'b0, lane_tot3}; // First level, high pair.
	assign total  = {1'b0, sum_lo} + {1'b0, sum_hi};       // Second level.

	assign s_red = {{(arith_pkg::WORD_W - 7){1'b0}}, total}; // Unsigned result.

endmodule

// File: rtl/cla_16bit.sv
// Sixteen-bit two-level carry-lookahead adder with word saturation, PADDSB lanes and RED.
`timescale 1ns/1ps

module cla_16bit (
	input  logic [arith_pkg::WORD_W-1:0] a,    // Addend A.
	input  logic [arith_pkg::WORD_W-1:0] b,    // Addend B, already inverted for SUB.
	input  logic                         sub,  // Carry-in for subtraction.
	input  logic                         sat,  // PADDSB selects the clamped lanes.
	input  logic                         red,  // RED selects the reduction total.
	output logic [arith_pkg::WORD_W-1:0] s,    // Selected result.
	output logic                         ovfl  // Word overflow for ADD and SUB.
);

	arith_pkg::arith_word_u a_u;   // Operand A seen as lanes.
	arith_pkg::arith_word_u b_u;   // Operand B seen as lanes.
	arith_pkg::arith_word_u s_raw; // Lane outputs joined into a word.
	logic [arith_pkg::LANES-1:0] lane_g;   // Lane generates.
	logic [arith_pkg::LANES-1:0] lane_p;   // Lane propagates.
	logic [arith_pkg::LANES-1:0] lane_cin; // Carry into each lane.
	logic c1;
	logic c2;
	logic c3;
	logic [arith_pkg::WORD_W-1:0] s_red;   // RED total.
	logic [arith_pkg::WORD_W-1:0] s_sat;   // Word-saturated sum.
	logic pos_ovfl;
	logic neg_ovfl;

	assign a_u.word = a;
	assign b_u.word = b;
	assign lane_cin = {c3, c2, c1, sub}; // Lane 0 takes the subtract carry.

	// ==============================
	// Lanes and lookahead
	// ==============================
	for (genvar i = 0; i < arith_pkg::LANES; i++) begin : g_lane
		cla_4bit u_lane (.a(a_u.lanes[i]), .b(b_u.lanes[i]), .c0(lane_cin[i]),
			.sat(sat), .red(red), .s(s_raw.lanes[i]), .g(lane_g[i]), .p(lane_p[i]));
	end

	// Word-level group terms only matter when adders are chained wider than 16 bits.
	cla_carry_block u_carry (.g_in(lane_g), .p_in(lane_p), .c0(sub),
		.c1(c1), .c2(c2), .c3(c3), .g_out(), .p_out());

	nibble_reduction u_reduction (.s0(s_raw.lanes[0]), .s1(s_raw.lanes[1]),
		.s2(s_raw.lanes[2]), .s3(s_raw.lanes[3]), .g0(lane_g[0]), .g1(lane_g[1]),
		.g2(lane_g[2]), .g3(lane_g[3]), .s_red(s_red));

	// ==============================
	// Word saturation and select
	// ==============================
	assign pos_ovfl = s_raw.word[15] & ~a[15] & ~b[15]; // Positive operands, negative sum.
	assign neg_ovfl = ~s_raw.word[15] & a[15] & b[15];  // Negative operands, positive sum.
	assign ovfl = (pos_ovfl | neg_ovfl) & ~(sat | red); // Lane modes never flag overflow.

	assign s_sat = pos_ovfl ? arith_pkg::SAT_POS :
		neg_ovfl ? arith_pkg::SAT_NEG :
		s_raw.word;

	assign s = red ? s_red :
		sat ? s_raw.word :
		s_sat; // RED wins, then PADDSB lanes, then the saturated word.

endmodule

// File: rtl/arith_stage.sv
// Execute stage that decodes the opcode, drives the adder and registers its result.
`timescale 1ns/1ps

module arith_stage (
	input  logic                         clk,
	input  logic                         reset,        // Synchronous, active high.
	input  logic [arith_pkg::WORD_W-1:0] operand_a,
	input  logic [arith_pkg::WORD_W-1:0] operand_b,
	input  logic [1:0]                   opcode,
	input  logic                         op_valid,     // Starts an operation.
	output logic [arith_pkg::WORD_W-1:0] result,
	output logic                         ovfl,
	output logic                         result_valid, // One-cycle pulse per operation.
	output logic [1:0]                   op_done_code  // Opcode of the registered result.
);

	logic                         sub;      // SUB decode.
	logic                         sat;      // PADDSB decode.
	logic                         red;      // RED decode.
	logic [arith_pkg::WORD_W-1:0] b_in;     // B after optional inversion.
	logic [arith_pkg::WORD_W-1:0] sum_word; // Adder output.
	logic                         sum_ovfl; // Adder overflow.
	arith_pkg::arith_word_u       result_q; // Registered result word.

	// ==============================
	// Decode and operand prep
	// ==============================
	assign sub  = (opcode == arith_pkg::OP_SUB);
	assign sat  = (opcode == arith_pkg::OP_PADDSB);
	assign red  = (opcode == arith_pkg::OP_RED);
	assign b_in = sub ? ~operand_b : operand_b; // Two's complement with carry-in = sub.

	cla_16bit u_adder (.a(operand_a), .b(b_in), .sub(sub), .sat(sat), .red(red),
		.s(sum_word), .ovfl(sum_ovfl));

	// ==============================
	// Result register
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			result_q.word <= '0;
			ovfl          <= 1'b0;
			result_valid  <= 1'b0;
			op_done_code  <= arith_pkg::OP_ADD;
		end else begin
			result_valid <= op_valid; // Pulse follows each accepted operation.
			if (op_valid) begin
				result_q.word <= sum_word;
				ovfl          <= sum_ovfl;
				op_done_code  <= opcode; // Flags need to know what produced the result.
			end
		end
	end

	assign result = result_q.word;

endmodule

// File: rtl/flag_register.sv
// Condition flag register that captures Z, V and N from each completed operation.
`timescale 1ns/1ps

module flag_register (
	input  logic                         clk,
	input  logic                         reset,        // Synchronous, active high.
	input  logic [arith_pkg::WORD_W-1:0] result,       // Registered result.
	input  logic                         ovfl,         // Registered overflow.
	input  logic                         result_valid, // Result is new this cycle.
	input  logic [1:0]                   op_done_code, // Opcode that made the result.
	output logic                         flag_z,       // Result was zero.
	output logic                         flag_v,       // Signed overflow.
	output logic                         flag_n        // Result was negative.
);

	logic word_op; // ADD or SUB, the ops that own V and N.

	assign word_op = (op_done_code == arith_pkg::OP_ADD) ||
		(op_done_code == arith_pkg::OP_SUB);

	// ==============================
	// Flag update
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			flag_z <= 1'b0;
			flag_v <= 1'b0;
			flag_n <= 1'b0;
		end else if (result_valid) begin
			flag_z <= (result == '0); // Every op sets Z.
			if (word_op) begin
				flag_v <= ovfl;
				flag_n <= result[arith_pkg::WORD_W-1]; // Sign of the word.
			end
			// Lane ops leave V and N as the last word op set them.
		end
	end

endmodule

// File: rtl/arith_unit.sv
// Saturating arithmetic unit top joining the execute stage to the flag register.
`timescale 1ns/1ps

module arith_unit (
	input  logic                         clk,
	input  logic                         reset,        // Synchronous, active high.
	input  logic [arith_pkg::WORD_W-1:0] operand_a,
	input  logic [arith_pkg::WORD_W-1:0] operand_b,
	input  logic [1:0]                   opcode,
	input  logic                         op_valid,     // One operation per strobe.
	output logic [arith_pkg::WORD_W-1:0] result,
	output logic                         ovfl,
	output logic                         result_valid, // One cycle after op_valid.
	output logic                         flag_z,       // Two cycles after op_valid.
	output logic                         flag_v,
	output logic                         flag_n
);

	logic [1:0] op_done_code; // Opcode travelling with the result.

	// ==============================
	// Execute and flags
	// ==============================
	arith_stage u_stage (.clk(clk), .reset(reset), .operand_a(operand_a),
		.operand_b(operand_b), .opcode(opcode), .op_valid(op_valid),
		.result(result), .ovfl(ovfl), .result_valid(result_valid),
		.op_done_code(op_done_code));

	flag_register u_flags (.clk(clk), .reset(reset), .result(result), .ovfl(ovfl),
		.result_valid(result_valid), .op_done_code(op_done_code),
		.flag_z(flag_z), .flag_v(flag_v), .flag_n(flag_n));

endmodule

// File: verif/arith_unit_sva.sv
// Bound checker with a reference model for the result, overflow, valid pulse and flags.
`timescale 1ns/1ps

module arith_unit_sva (
	input logic                         clk,
	input logic                         reset,
	input logic [arith_pkg::WORD_W-1:0] operand_a,
	input logic [arith_pkg::WORD_W-1:0] operand_b,
	input logic [1:0]                   opcode,
	input logic                         op_valid,
	input logic [arith_pkg::WORD_W-1:0] result,
	input logic                         ovfl,
	input logic                         result_valid,
	input logic                         flag_z,
	input logic                         flag_v,
	input logic                         flag_n
);

	logic                         assert_failed = 1'b0; // Rises on the first failed check.
	logic [arith_pkg::WORD_W-1:0] exp_word;  // Modeled result of the last operation.
	logic                         exp_ovfl;  // Modeled overflow.
	logic                         exp_valid; // Modeled result_valid pulse.
	logic [1:0]                   exp_code;  // Opcode of the modeled result.
	logic                         exp_z;
	logic                         exp_v;
	logic                         exp_n;

	// ==============================
	// Reference model
	// ==============================
	// Returns {ovfl, result} for one operation, worked out in plain integers.
	function automatic logic [arith_pkg::WORD_W:0] model_op(input logic [15:0] a,
		input logic [15:0] b, input logic [1:0] op);
		arith_pkg::arith_word_u ua;
		arith_pkg::arith_word_u ub;
		arith_pkg::arith_word_u ur;
		int sa;
		int sb;
		int total;
		int la;
		int lb;
		int i;
		logic flag;
		ua.word = a;
		ub.word = b;
		ur.word = '0;
		flag    = 1'b0;
		sa      = $signed(a); // Sign-extended operands.
		sb      = $signed(b);
		total   = 0;
		case (op)
			arith_pkg::OP_ADD, arith_pkg::OP_SUB: begin
				total = (op == arith_pkg::OP_SUB) ? sa - sb : sa + sb; // Exact sum.
				flag  = (total > 32767) || (total < -32768);           // Out of 16-bit range.
				if (total > 32767) ur.word = arith_pkg::SAT_POS;
				else if (total < -32768) ur.word = arith_pkg::SAT_NEG;
				else ur.word = total[15:0];
			end
			arith_pkg::OP_PADDSB: begin
				for (i = 0; i < arith_pkg::LANES; i++) begin
					la    = $signed(ua.lanes[i]); // Signed lane values.
					lb    = $signed(ub.lanes[i]);
					total = la + lb;
					if (total > 7) total = 7;   // Clamp high.
					if (total < -8) total = -8; // Clamp low.
					ur.lanes[i] = total[3:0];
				end
			end
			default: begin
				for (i = 0; i < arith_pkg::LANES; i++) begin
					total = total + ua.lanes[i] + ub.lanes[i]; // Unsigned nibble total.
				end
				ur.word = total[15:0];
			end
		endcase
		return {flag, ur.word};
	endfunction

	// The result follows op_valid by one cycle and the flags follow by one more.
	always_ff @(posedge clk) begin
		if (reset) begin
			exp_word  <= '0;
			exp_ovfl  <= 1'b0;
			exp_valid <= 1'b0;
			exp_code  <= arith_pkg::OP_ADD;
			exp_z     <= 1'b0;
			exp_v     <= 1'b0;
			exp_n     <= 1'b0;
		end else begin
			exp_valid <= op_valid;
			if (op_valid) begin
				{exp_ovfl, exp_word} <= model_op(operand_a, operand_b, opcode);
				exp_code <= opcode;
			end
			if (exp_valid) begin
				exp_z <= (exp_word == '0); // Z follows every operation.
				if (exp_code == arith_pkg::OP_ADD || exp_code == arith_pkg::OP_SUB) begin
					exp_v <= exp_ovfl;
					exp_n <= exp_word[15]; // V and N only for word ops.
				end
			end
		end
	end

	// ==============================
	// Assertions
	// ==============================
	a_reset_zero: assert property (@(posedge clk) $fell(reset) |-> (result == '0 &&
		!ovfl && !result_valid && !flag_z && !flag_v && !flag_n))
		else begin
			$error("MISMATCH t=%0t outputs not zero after reset", $time);
			assert_failed = 1'b1;
		end

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		result_valid == exp_valid)
		else begin
			$error("MISMATCH t=%0t result_valid %b, expected %b", $time,
				$sampled(result_valid), $sampled(exp_valid));
			assert_failed = 1'b1;
		end

	a_result: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> (result == exp_word && ovfl == exp_ovfl))
		else begin
			$error("MISMATCH t=%0t result %h ovfl %b, expected %h ovfl %b", $time,
				$sampled(result), $sampled(ovfl), $sampled(exp_word), $sampled(exp_ovfl));
			assert_failed = 1'b1;
		end

	a_flags: assert property (@(posedge clk) disable iff (reset)
		{flag_z, flag_v, flag_n} == {exp_z, exp_v, exp_n})
		else begin
			$error("MISMATCH t=%0t flags zvn %b%b%b, expected %b%b%b", $time,
				$sampled(flag_z), $sampled(flag_v), $sampled(flag_n),
				$sampled(exp_z), $sampled(exp_v), $sampled(exp_n));
			assert_failed = 1'b1;
		end

endmodule

bind arith_unit arith_unit_sva u_sva (.*);

// File: verif/tb_arith_unit.sv
// Testbench for the saturating arithmetic unit with directed corners and LFSR stimulus.
`timescale 1ns/1ps

module tb_arith_unit;

	logic                         clk = 1'b0;
	logic                         reset;
	logic [arith_pkg::WORD_W-1:0] operand_a;
	logic [arith_pkg::WORD_W-1:0] operand_b;
	logic [1:0]                   opcode;
	logic                         op_valid;
	logic [arith_pkg::WORD_W-1:0] result;
	logic                         ovfl;
	logic                         result_valid;
	logic                         flag_z;
	logic                         flag_v;
	logic                         flag_n;
	logic [31:0]                  lfsr_state = 32'h8d6d_a087; // Random stream state.
	int                           cycle_count = 0;            // Clock edges since start.

	arith_unit DUT (.clk(clk), .reset(reset), .operand_a(operand_a),
		.operand_b(operand_b), .opcode(opcode), .op_valid(op_valid),
		.result(result), .ovfl(ovfl), .result_valid(result_valid),
		.flag_z(flag_z), .flag_v(flag_v), .flag_n(flag_n));

	always #10 clk = ~clk; // 20 ns period.

	// ==============================
	// Stimulus helpers
	// ==============================
	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state); // One step per bit taken.
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	task automatic issue_op(input logic [15:0] a, input logic [15:0] b, input logic [1:0] op);
		@(posedge clk);
		#2;
		operand_a = a;
		operand_b = b;
		opcode    = op;
		op_valid  = 1'b1; // Held high across calls for back-to-back ops.
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2;
		op_valid = 1'b0;
	endtask

	// ==============================
	// Watchdogs
	// ==============================
	// Reset plus at most two cycles for each of the 416 operations fits well under 1000.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == 1000) begin
			$display("Timeout: the run did not finish within 1000 cycles.");
			$display("TB FAILED");
			$fatal(1, "Simulation stopped on timeout.");
		end
	end

	always @(posedge DUT.u_sva.assert_failed) begin
		$display("TB FAILED");
		$fatal(1, "A bound assertion failed.");
	end

	initial begin
		logic [15:0] a_rand;
		logic [15:0] b_rand;
		logic [15:0] op_rand;
		logic [15:0] gap;
		reset     = 1'b1;
		operand_a = '0;
		operand_b = '0;
		opcode    = arith_pkg::OP_ADD;
		op_valid  = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		// Directed corners go out back to back.
		issue_op(16'h7FFF, 16'h0001, arith_pkg::OP_ADD);    // Saturates to 7FFF.
		issue_op(16'h8000, 16'h0001, arith_pkg::OP_SUB);    // Saturates to 8000.
		issue_op(16'h0000, 16'h8000, arith_pkg::OP_SUB);    // Negating 8000 saturates.
		issue_op(16'h8000, 16'h8000, arith_pkg::OP_ADD);
		issue_op(16'h1234, 16'h4321, arith_pkg::OP_ADD);
		issue_op(16'h0005, 16'h0005, arith_pkg::OP_SUB);    // Zero result.
		issue_op(16'h7831, 16'h1F21, arith_pkg::OP_PADDSB); // Lanes clamp both ways.
		issue_op(16'hFFFF, 16'h0001, arith_pkg::OP_PADDSB); // No carry between lanes.
		issue_op(16'h0000, 16'h0000, arith_pkg::OP_PADDSB); // Sets Z and keeps V and N.
		issue_op(16'hFFFF, 16'hFFFF, arith_pkg::OP_RED);    // Total of 120.
		issue_op(16'h0000, 16'h0000, arith_pkg::OP_RED);
		issue_op(16'hFFFF, 16'h0001, arith_pkg::OP_ADD);    // Wraps to zero legally.
		issue_op(16'h8000, 16'h8000, arith_pkg::OP_SUB);
		issue_op(16'h4444, 16'h4444, arith_pkg::OP_PADDSB); // Every lane clamps to 7.
		issue_op(16'h1234, 16'h5678, arith_pkg::OP_RED);
		issue_op(16'h8000, 16'hFFFF, arith_pkg::OP_ADD);
		idle_cycle();
		for (int n = 0; n < 400; n++) begin
			take_bits(2, op_rand);
			take_bits(16, a_rand);
			take_bits(16, b_rand);
			issue_op(a_rand, b_rand, op_rand[1:0]);
			take_bits(1, gap);
			if (gap[0]) idle_cycle(); // Either one idle cycle or straight back to back.
		end
		idle_cycle();
		repeat (3) @(posedge clk); // Let the last flags settle and be checked.
		if (DUT.u_sva.assert_failed) begin
			$display("TB FAILED");
			$fatal(1, "A bound assertion failed.");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// File: list.f
rtl/arith_pkg.sv
rtl/cla_4bit.sv
rtl/cla_carry_block.sv
rtl/nibble_reduction.sv
rtl/cla_16bit.sv
rtl/arith_stage.sv
rtl/flag_register.sv
rtl/arith_unit.sv
verif/arith_unit_sva.sv
verif/tb_arith_unit.sv
